// ==== src/ethTxPkg.sv ====
package ethTxPkg;

    // ------------------------------------------------------------
    // source arbitration
    // ------------------------------------------------------------
    localparam int NumPorts = 4;                           // frame sources
    localparam int PortIdxWidth = (NumPorts > 1) ? $clog2(NumPorts) : 1;

    // ------------------------------------------------------------
    // frame layout on the wire
    // ------------------------------------------------------------
    localparam logic [7:0] PreambleByte = 8'h55;
    localparam logic [7:0] SfdByte = 8'hD5;                // start of frame delimiter
    localparam int PreambleLen = 7;                        // preamble bytes ahead of the SFD

    // minimum idle between frames, in byte times
    localparam int IfgBytes = 12;

    localparam int FcsBytes = 4;                           // appended check sequence

    // ------------------------------------------------------------
    // ethernet CRC-32, reflected form
    // ------------------------------------------------------------
    localparam logic [31:0] CrcPoly = 32'hEDB8_8320;
    localparam logic [31:0] CrcInit = 32'hFFFF_FFFF;       // all ones at frame start
    localparam logic [31:0] CrcXorOut = 32'hFFFF_FFFF;     // final inversion

endpackage

// ==== src/ethTxScheduler.sv ====
`timescale 1ns/1ps

module ethTxScheduler (
    input  logic Clk,
    input  logic rst,
    input  logic LinkUp,
    input  logic [ethTxPkg::NumPorts-1:0] ReqIn,
    input  logic [ethTxPkg::NumPorts-1:0] ValIn,
    input  logic [ethTxPkg::NumPorts-1:0] SoFIn,
    input  logic [ethTxPkg::NumPorts-1:0] EoFIn,
    input  logic [ethTxPkg::NumPorts-1:0][7:0] DataIn,
    input  logic Busy,
    input  logic GapDone,
    output logic [ethTxPkg::NumPorts-1:0] ReqConfirm,
    output logic ByteVal,
    output logic ByteSoF,
    output logic ByteEoF,
    output logic [7:0] ByteData
);

    typedef enum logic [1:0] {
        Idle,
        Grant,
        Stream
    } stateT;

    stateT state;
    logic linkUpReg;
    logic [ethTxPkg::PortIdxWidth-1:0] grantIdx;   // also the round-robin pointer
    logic [ethTxPkg::PortIdxWidth-1:0] nextIdx;
    logic reqFound;
    logic valSel;
    logic sofSel;
    logic eofSel;
    logic grantOk;

    // strobes of the granted source
    assign valSel = ValIn[grantIdx] & (state != Idle);
    assign sofSel = SoFIn[grantIdx];
    assign eofSel = EoFIn[grantIdx];

    // the last forwarded byte must leave the output register first,
    // otherwise a one-byte frame could be followed before Busy rises
    assign grantOk = (state == Idle) & ~Busy & GapDone & linkUpReg & ~ByteVal;

    // ------------------------------------------------------------
    // round-robin search, starting one past the last grant
    // ------------------------------------------------------------
    always_comb begin
        reqFound = 1'b0;
        nextIdx = grantIdx;
        for (int i = 1; i <= ethTxPkg::NumPorts; i++) begin
            if (!reqFound && ReqIn[(int'(grantIdx) + i) % ethTxPkg::NumPorts]) begin
                reqFound = 1'b1;
                nextIdx = ethTxPkg::PortIdxWidth'((int'(grantIdx) + i) % ethTxPkg::NumPorts);
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            state <= Idle;
            ReqConfirm <= '0;
            grantIdx <= ethTxPkg::PortIdxWidth'(ethTxPkg::NumPorts - 1);  // first search hits 0
            linkUpReg <= 1'b0;
            ByteVal <= 1'b0;
            ByteSoF <= 1'b0;
            ByteEoF <= 1'b0;
        end else begin
            linkUpReg <= LinkUp;
            ByteVal <= valSel;
            ByteSoF <= valSel & sofSel;
            ByteEoF <= valSel & eofSel;

            case (state)
                Idle: begin
                    if (grantOk && reqFound) begin
                        state <= Grant;
                        grantIdx <= nextIdx;
                        ReqConfirm <= ethTxPkg::NumPorts'(1) << nextIdx;
                    end
                end
                Grant: begin                       // wait for the first byte
                    if (valSel && sofSel) begin
                        state <= eofSel ? Idle : Stream;
                        if (eofSel) ReqConfirm <= '0;  // one-byte frame
                    end
                end
                Stream: begin
                    if (valSel && eofSel) begin
                        state <= Idle;
                        ReqConfirm <= '0;
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        ByteData <= DataIn[grantIdx];
    end

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------
    assert property (@(posedge Clk) disable iff (rst) $onehot0(ReqConfirm));

    // only the granted source may talk
    assert property (@(posedge Clk) disable iff (rst) (ValIn & ~ReqConfirm) == '0);

    // no back-pressure, a stalled source breaks the frame
    assert property (@(posedge Clk) disable iff (rst)
        (valSel && !eofSel) |=> !valSel ##1 valSel);

endmodule

// ==== src/ethTxByteTimer.sv ====
`timescale 1ns/1ps

module ethTxByteTimer (
    input  logic Clk,
    input  logic rst,
    input  logic ByteVal,
    input  logic FrameEnd,
    output logic SlotStrobe,
    output logic GapDone
);

    logic [$clog2(ethTxPkg::IfgBytes * 2)-1:0] gapCnt;

    // ------------------------------------------------------------
    // byte slot phase
    // ------------------------------------------------------------
    // free running toggle, forced high after every valid byte so the
    // slot lines up with the source stream whatever phase it starts on
    always_ff @(posedge Clk) begin
        if (rst) begin
            SlotStrobe <= 1'b0;
        end else begin
            SlotStrobe <= ByteVal | ~SlotStrobe;
        end
    end

    // ------------------------------------------------------------
    // interframe gap
    // ------------------------------------------------------------
    always_ff @(posedge Clk) begin
        if (rst) begin
            gapCnt <= '0;
            GapDone <= 1'b1;
        end else if (FrameEnd) begin
            // GapDone low one cycle later, high again two byte times x IfgBytes on
            gapCnt <= $bits(gapCnt)'(ethTxPkg::IfgBytes * 2 - 2);
            GapDone <= 1'b0;
        end else if (gapCnt != '0) begin
            gapCnt <= gapCnt - 1'b1;
            GapDone <= (gapCnt == 1);        // last count releases the scheduler
        end
    end

    // bytes come on alternate cycles at most
    assert property (@(posedge Clk) disable iff (rst) ByteVal |=> !ByteVal);

endmodule

// ==== src/ethCrc32.sv ====
`timescale 1ns/1ps

module ethCrc32 (
    input  logic Clk,
    input  logic rst,
    input  logic ByteVal,
    input  logic ByteSoF,
    input  logic ByteEoF,
    input  logic [7:0] ByteData,
    output logic [31:0] Crc,
    output logic CrcRdy
);

    logic [31:0] crcReg;
    logic [31:0] crcSeed;

    // one byte through the reflected LFSR, bit 0 first
    function automatic logic [31:0] crcByte(input logic [31:0] crcIn, input logic [7:0] data);
        logic [31:0] r;
        r = crcIn;
        for (int b = 0; b < 8; b++) begin
            if (r[0] ^ data[b]) begin
                r = (r >> 1) ^ ethTxPkg::CrcPoly;
            end else begin
                r = r >> 1;
            end
        end
        return r;
    endfunction

    // restart on the first byte of every frame
    assign crcSeed = ByteSoF ? ethTxPkg::CrcInit : crcReg;

    always_ff @(posedge Clk) begin
        if (ByteVal) begin
            crcReg <= crcByte(crcSeed, ByteData);
        end
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            CrcRdy <= 1'b0;
        end else begin
            CrcRdy <= ByteVal & ByteEoF;     // register already holds the final value
        end
    end

    // byte 0 of Crc goes out first
    assign Crc = crcReg ^ ethTxPkg::CrcXorOut;

endmodule

// ==== src/ethTxFramer.sv ====
`timescale 1ns/1ps

module ethTxFramer (
    input  logic Clk,
    input  logic rst,
    input  logic ByteVal,
    input  logic ByteSoF,
    input  logic ByteEoF,
    input  logic [7:0] ByteData,
    input  logic SlotStrobe,
    input  logic [31:0] Crc,
    input  logic CrcRdy,
    output logic TxEn,
    output logic [3:0] TxData,
    output logic FrameEnd,
    output logic Busy
);

    // delay line, index PreambleLen is the head on the wire side
    logic [ethTxPkg::PreambleLen:0][7:0] lineByte;
    logic [ethTxPkg::PreambleLen:0] lineVal;

    logic [7:0] inByte;                  // byte waiting for the next slot
    logic inVal;
    logic [31:0] fcsByte;
    logic [$clog2(ethTxPkg::FcsBytes + 1)-1:0] fcsCnt;
    logic awaitFcs;                      // EoF seen, CRC not yet taken
    logic [3:0] txHi;

    logic sofLoad;
    logic fcsPending;
    logic shiftVal;
    logic [7:0] shiftByte;
    logic headVal;
    logic [7:0] headByte;

    assign sofLoad = ByteVal & ByteSoF;
    assign fcsPending = (fcsCnt != '0);
    assign shiftVal = inVal | fcsPending;
    assign shiftByte = inVal ? inByte : fcsByte[7:0];    // payload first, then FCS
    assign headVal = lineVal[ethTxPkg::PreambleLen];
    assign headByte = lineByte[ethTxPkg::PreambleLen];

    // ------------------------------------------------------------
    // byte path
    // ------------------------------------------------------------
    always_ff @(posedge Clk) begin
        if (ByteVal) inByte <= ByteData;

        if (sofLoad) begin
            for (int i = 1; i <= ethTxPkg::PreambleLen; i++) begin
                lineByte[i] <= ethTxPkg::PreambleByte;
            end
            lineByte[0] <= ethTxPkg::SfdByte;
        end else if (SlotStrobe) begin
            lineByte <= {lineByte[ethTxPkg::PreambleLen-1:0], shiftByte};
        end

        if (CrcRdy && awaitFcs) begin
            fcsByte <= Crc;
        end else if (SlotStrobe && !inVal && fcsPending) begin
            fcsByte <= fcsByte >> 8;
        end

        if (SlotStrobe) txHi <= headByte[7:4];
    end

    // ------------------------------------------------------------
    // slot valids and frame control
    // ------------------------------------------------------------
    always_ff @(posedge Clk) begin
        if (rst) begin
            lineVal <= '0;
            inVal <= 1'b0;
            fcsCnt <= '0;
            awaitFcs <= 1'b0;
            Busy <= 1'b0;
        end else begin
            if (ByteVal) inVal <= 1'b1;
            else if (SlotStrobe) inVal <= 1'b0;

            if (sofLoad) lineVal <= '1;                   // preamble and SFD slots
            else if (SlotStrobe) lineVal <= {lineVal[ethTxPkg::PreambleLen-1:0], shiftVal};

            if (CrcRdy && awaitFcs) begin
                fcsCnt <= ($bits(fcsCnt))'(ethTxPkg::FcsBytes);
            end else if (SlotStrobe && !inVal && fcsPending) begin
                fcsCnt <= fcsCnt - 1'b1;
            end

            if (ByteVal && ByteEoF) awaitFcs <= 1'b1;
            else if (CrcRdy) awaitFcs <= 1'b0;

            if (sofLoad) Busy <= 1'b1;
            else if (FrameEnd) Busy <= 1'b0;              // drops as the gap timer starts
        end
    end

    // ------------------------------------------------------------
    // nibble output, low nibble first
    // ------------------------------------------------------------
    always_ff @(posedge Clk) begin
        if (rst) begin
            TxEn <= 1'b0;
            TxData <= 4'h0;
            FrameEnd <= 1'b0;
        end else if (SlotStrobe) begin
            TxEn <= headVal;
            TxData <= headVal ? headByte[3:0] : 4'h0;
            FrameEnd <= TxEn & ~headVal;                  // first cycle with TxEn low
        end else begin
            TxData <= TxEn ? txHi : 4'h0;
            FrameEnd <= 1'b0;
        end
    end

    // the CRC result belongs to a frame still held in the framer
    assert property (@(posedge Clk) disable iff (rst) CrcRdy |-> Busy);

endmodule

// ==== src/ethTxTop.sv ====
`timescale 1ns/1ps

module ethTxTop (
    input  logic Clk,
    input  logic rst,
    input  logic LinkUp,
    input  logic [ethTxPkg::NumPorts-1:0] ReqIn,
    input  logic [ethTxPkg::NumPorts-1:0] ValIn,
    input  logic [ethTxPkg::NumPorts-1:0] SoFIn,
    input  logic [ethTxPkg::NumPorts-1:0] EoFIn,
    input  logic [ethTxPkg::NumPorts-1:0][7:0] DataIn,
    output logic [ethTxPkg::NumPorts-1:0] ReqConfirm,
    output logic TxEn,
    output logic [3:0] TxData
);

    // granted byte stream
    logic byteVal;
    logic byteSoF;
    logic byteEoF;
    logic [7:0] byteData;

    logic busy;
    logic gapDone;
    logic slotStrobe;
    logic frameEnd;
    logic [31:0] crc;
    logic crcRdy;

    ethTxScheduler scheduler (
        .Clk        (Clk),
        .rst        (rst),
        .LinkUp     (LinkUp),
        .ReqIn      (ReqIn),
        .ValIn      (ValIn),
        .SoFIn      (SoFIn),
        .EoFIn      (EoFIn),
        .DataIn     (DataIn),
        .Busy       (busy),
        .GapDone    (gapDone),
        .ReqConfirm (ReqConfirm),
        .ByteVal    (byteVal),
        .ByteSoF    (byteSoF),
        .ByteEoF    (byteEoF),
        .ByteData   (byteData)
    );

    ethTxByteTimer byteTimer (
        .Clk        (Clk),
        .rst        (rst),
        .ByteVal    (byteVal),
        .FrameEnd   (frameEnd),
        .SlotStrobe (slotStrobe),
        .GapDone    (gapDone)
    );

    ethCrc32 crc32 (
        .Clk        (Clk),
        .rst        (rst),
        .ByteVal    (byteVal),
        .ByteSoF    (byteSoF),
        .ByteEoF    (byteEoF),
        .ByteData   (byteData),
        .Crc        (crc),
        .CrcRdy     (crcRdy)
    );

    ethTxFramer framer (
        .Clk        (Clk),
        .rst        (rst),
        .ByteVal    (byteVal),
        .ByteSoF    (byteSoF),
        .ByteEoF    (byteEoF),
        .ByteData   (byteData),
        .SlotStrobe (slotStrobe),
        .Crc        (crc),
        .CrcRdy     (crcRdy),
        .TxEn       (TxEn),
        .TxData     (TxData),
        .FrameEnd   (frameEnd),
        .Busy       (busy)
    );

endmodule

// ==== verification/ethTxClkGen.sv ====
`timescale 1ns/1ps

module ethTxClkGen (
    output logic Clk,
    output logic rst
);

    initial begin
        Clk = 1'b0;
        forever #50 Clk = ~Clk;      // 100 ns period
    end

    // reset held for four rising edges, released just after the last one
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge Clk);
        #1;
        rst = 1'b0;
    end

endmodule

// ==== verification/ethTxTb.sv ====
`timescale 1ns/1ps

module ethTxTb;

    typedef logic [7:0] byteQ[$];

    logic Clk;
    logic rst;
    logic LinkUp;
    logic [ethTxPkg::NumPorts-1:0] ReqIn;
    logic [ethTxPkg::NumPorts-1:0] ValIn;
    logic [ethTxPkg::NumPorts-1:0] SoFIn;
    logic [ethTxPkg::NumPorts-1:0] EoFIn;
    logic [ethTxPkg::NumPorts-1:0][7:0] DataIn;
    logic [ethTxPkg::NumPorts-1:0] ReqConfirm;
    logic TxEn;
    logic [3:0] TxData;

    byteQ srcBytes [ethTxPkg::NumPorts];         // payload bytes waiting per source
    int srcLens [ethTxPkg::NumPorts][$];
    byteQ expBytes;                              // expected wire images, back to back
    int expLens[$];
    string expNames[$];
    byteQ rxBytes;                               // bytes rebuilt from TxData
    int rxLens[$];

    string testName = "reset";
    int testBase = 0;
    int testsRun = 0;
    int testsFailed = 0;
    int mainErrors = 0;
    int rxErrors = 0;
    int cmpErrors = 0;
    int gapErrors = 0;
    int gapsSeen = 0;
    int framesQueued = 0;
    int framesChecked = 0;
    int framesSeen = 0;
    logic aborted = 1'b0;

    // collector state
    logic rxActive = 1'b0;
    logic nibHigh = 1'b0;
    logic [3:0] lowNib = 4'h0;
    int rxCount = 0;
    int idleCycles = 0;

    ethTxClkGen clkGen (.Clk(Clk), .rst(rst));

    ethTxTop i_dut (
        .Clk        (Clk),
        .rst        (rst),
        .LinkUp     (LinkUp),
        .ReqIn      (ReqIn),
        .ValIn      (ValIn),
        .SoFIn      (SoFIn),
        .EoFIn      (EoFIn),
        .DataIn     (DataIn),
        .ReqConfirm (ReqConfirm),
        .TxEn       (TxEn),
        .TxData     (TxData)
    );

    // ------------------------------------------------------------
    // frame sources, one process each
    // ------------------------------------------------------------
    for (genvar p = 0; p < ethTxPkg::NumPorts; p++) begin : srcGen
        logic req;
        logic val;
        logic sof;
        logic eof;
        logic [7:0] data;

        assign ReqIn[p] = req;
        assign ValIn[p] = val;
        assign SoFIn[p] = sof;
        assign EoFIn[p] = eof;
        assign DataIn[p] = data;

        initial begin
            int remaining;
            logic inFrame;
            logic skipNext;
            remaining = 0;
            inFrame = 1'b0;
            skipNext = 1'b0;
            {req, val, sof, eof, data} = '0;
            forever begin
                @(posedge Clk);
                #1;                                // drive just after the edge
                val = 1'b0;
                sof = 1'b0;
                eof = 1'b0;
                if (inFrame && skipNext) begin
                    skipNext = 1'b0;               // idle cycle between bytes
                end else if (inFrame || (ReqConfirm[p] && srcLens[p].size() != 0)) begin
                    if (!inFrame) begin
                        remaining = srcLens[p].pop_front();
                        sof = 1'b1;
                    end
                    val = 1'b1;
                    data = srcBytes[p].pop_front();
                    remaining--;
                    eof = (remaining == 0);
                    inFrame = (remaining != 0);
                    skipNext = 1'b1;
                end
                req = inFrame || (srcLens[p].size() != 0);
            end
        end
    end

    // ------------------------------------------------------------
    // collector, nibbles sampled on the falling edge
    // ------------------------------------------------------------
    always @(negedge Clk) begin
        if (TxEn) begin
            if (!rxActive && framesSeen != 0) begin
                gapsSeen++;
                if (idleCycles < ethTxPkg::IfgBytes * 2) begin
                    $display("error interframeGap idle cycles expected >= %0d actual %0d",
                             ethTxPkg::IfgBytes * 2, idleCycles);
                    gapErrors++;
                end
            end
            if (nibHigh) begin
                rxBytes.push_back({TxData, lowNib});
                rxCount++;
            end else begin
                lowNib = TxData;                   // low nibble comes first
            end
            nibHigh = ~nibHigh;
            rxActive = 1'b1;
            idleCycles = 0;
        end else begin
            if (rxActive) begin
                rxLens.push_back(rxCount);
                framesSeen++;
                if (nibHigh) begin
                    $display("frame in %s ended after an odd number of nibbles", testName);
                    rxErrors++;
                end
            end
            rxActive = 1'b0;
            nibHigh = 1'b0;
            rxCount = 0;
            idleCycles++;
        end
        if ($countones(ReqConfirm) > 1) begin
            $display("error %s ReqConfirm expected one-hot actual %b", testName, ReqConfirm);
            rxErrors++;
        end
    end

    // expected wire image: preamble, SFD, payload, FCS low byte first
    function automatic byteQ buildWireImage(byteQ payload);
        byteQ image;
        logic [31:0] fcs;
        logic feedback;
        fcs = ethTxPkg::CrcInit;
        for (int i = 0; i < ethTxPkg::PreambleLen; i++) begin
            image.push_back(ethTxPkg::PreambleByte);
        end
        image.push_back(ethTxPkg::SfdByte);
        foreach (payload[k]) begin
            image.push_back(payload[k]);
            for (int b = 0; b < 8; b++) begin      // serial LFSR, bit 0 first
                feedback = fcs[0] ^ payload[k][b];
                fcs = {1'b0, fcs[31:1]} ^ (feedback ? ethTxPkg::CrcPoly : 32'h0);
            end
        end
        fcs = fcs ^ ethTxPkg::CrcXorOut;
        for (int n = 0; n < ethTxPkg::FcsBytes; n++) begin
            image.push_back(fcs[8 * n +: 8]);
        end
        return image;
    endfunction

    // ------------------------------------------------------------
    // compare process, one received frame at a time
    // ------------------------------------------------------------
    initial begin
        int rxLen;
        int expLen;
        string name;
        logic [7:0] got;
        logic [7:0] want;
        logic mismatch;
        forever begin
            @(posedge Clk);
            if (rxLens.size() != 0) begin
                rxLen = rxLens.pop_front();
                expLen = 0;
                name = "unexpected";
                if (expLens.size() != 0) begin
                    expLen = expLens.pop_front();
                    name = expNames.pop_front();
                end
                mismatch = (rxLen != expLen);
                if (mismatch) begin
                    $display("error %s frame length expected %0d actual %0d", name, expLen, rxLen);
                end
                for (int i = 0; i < rxLen || i < expLen; i++) begin
                    got = 8'h00;
                    want = 8'h00;
                    if (i < rxLen) got = rxBytes.pop_front();
                    if (i < expLen) want = expBytes.pop_front();
                    if (!mismatch && got != want) begin
                        $display("error %s byte %0d expected %02h actual %02h", name, i, want, got);
                        mismatch = 1'b1;
                    end
                end
                if (mismatch) cmpErrors++;
                framesChecked++;
            end
        end
    end

    // ------------------------------------------------------------
    // test helpers
    // ------------------------------------------------------------
    task automatic startTest(input string name);
        testName = name;
        testBase = rxErrors + cmpErrors + mainErrors;
    endtask

    task automatic endTest();
        int errs;
        errs = rxErrors + cmpErrors + mainErrors - testBase;
        testsRun++;
        if (errs == 0) begin
            $display("test %s passed", testName);
        end else begin
            $display("test %s failed with %0d errors", testName, errs);
            testsFailed++;
        end
    endtask

    task automatic queueFrame(input int port, input int len, input logic withTag);
        byteQ payload;
        byteQ image;
        for (int i = 0; i < len; i++) begin
            payload.push_back(8'($urandom));
        end
        if (withTag) payload[0] = 8'(port);        // source tag for the order check
        image = buildWireImage(payload);
        foreach (payload[i]) srcBytes[port].push_back(payload[i]);
        foreach (image[i]) expBytes.push_back(image[i]);
        expLens.push_back(image.size());
        expNames.push_back(testName);
        srcLens[port].push_back(len);
        framesQueued++;
    endtask

    task automatic waitChecked(input int target, input int limit);
        int cycles;
        cycles = 0;
        while (framesChecked < target && cycles < limit) begin
            @(posedge Clk);
            cycles++;
        end
        if (framesChecked < target) begin
            $display("timeout in %s, frame %0d never came out on TxData", testName, target);
            mainErrors++;
            aborted = 1'b1;
        end
    endtask

    task automatic waitReset();
        int cycles;
        cycles = 0;
        while (rst && cycles < 20) begin
            @(posedge Clk);
            cycles++;
        end
        if (rst) begin
            $display("reset was never released");
            mainErrors++;
            aborted = 1'b1;
        end
    endtask

    // ------------------------------------------------------------
    // tests
    // ------------------------------------------------------------
    task automatic sendFirstFrame();
        if (aborted) return;
        startTest("firstFrame");
        @(negedge Clk);
        if (TxEn !== 1'b0 || ReqConfirm !== '0) begin
            $display("error firstFrame TxEn expected 0 actual %b, ReqConfirm expected 0 actual %b",
                     TxEn, ReqConfirm);
            mainErrors++;
        end
        queueFrame(0, 60, 1'b0);
        waitChecked(framesQueued, 400);
        endTest();
    endtask

    task automatic holdLinkDown();
        logic flagged;
        if (aborted) return;
        startTest("linkDown");
        flagged = 1'b0;
        @(posedge Clk);
        #1;
        LinkUp = 1'b0;
        @(negedge Clk);
        queueFrame(3, 32, 1'b0);
        repeat (300) begin
            @(negedge Clk);
            if (!flagged && (ReqConfirm != '0 || TxEn)) begin
                $display("error linkDown ReqConfirm expected 0 actual %b, TxEn expected 0 actual %b",
                         ReqConfirm, TxEn);
                mainErrors++;
                flagged = 1'b1;
            end
        end
        @(posedge Clk);
        #1;
        LinkUp = 1'b1;
        waitChecked(framesQueued, 400);
        endTest();
    endtask

    // last grant went to source 3, so the search restarts at 0
    task automatic rotateSources();
        if (aborted) return;
        startTest("roundRobin");
        @(negedge Clk);
        for (int rep = 0; rep < 2; rep++) begin
            queueFrame(0, 16 + rep * 20, 1'b1);
            queueFrame(2, 16 + rep * 20, 1'b1);
            queueFrame(3, 16 + rep * 20, 1'b1);
        end
        waitChecked(framesQueued, 1500);
        endTest();
    endtask

    task automatic sendRandomFrames();
        int port;
        int len;
        if (aborted) return;
        startTest("randomFrames");
        for (int k = 0; k < 30 && !aborted; k++) begin
            port = int'($urandom % ethTxPkg::NumPorts);
            len = 1 + int'($urandom % 64);
            if (k % 10 == 4) len = 1;              // a few single byte frames
            @(negedge Clk);
            queueFrame(port, len, 1'b0);
            waitChecked(framesQueued, 500);
        end
        endTest();
    endtask

    task automatic reportGap();
        startTest("interframeGap");
        if (gapsSeen == 0) begin
            $display("no consecutive frames were seen, so the gap was never measured");
            mainErrors++;
        end
        mainErrors = mainErrors + gapErrors;
        endTest();
    endtask

    initial begin
        void'($urandom(32'h6d44));
        LinkUp = 1'b1;
        waitReset();
        sendFirstFrame();
        holdLinkDown();
        rotateSources();
        sendRandomFrames();
        reportGap();
        $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed,
                 rxErrors + cmpErrors + mainErrors);
        if (rxErrors + cmpErrors + mainErrors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
src/ethTxPkg.sv
src/ethTxScheduler.sv
src/ethTxByteTimer.sv
src/ethCrc32.sv
src/ethTxFramer.sv
src/ethTxTop.sv
verification/ethTxClkGen.sv
verification/ethTxTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the Ethernet transmit testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module ethTxTb -f sources.f --Mdir "$BUILD" -o ethTxSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD/ethTxSim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
    exit 1
fi
exit 0
